// File: hdl/uartFramePkg.sv
package uartFramePkg;

    // One frame is a start bit, DataBits data bits sent LSB first, and a single stop bit.
    localparam int DataBits = 8;

    localparam int ClksPerBitWidth = 16;  // width of the run-time bit period input.

    // the receiver needs at least two cycles before its half-bit start check.
    localparam int MinClksPerBit = 4;

    // a received frame as it is queued for the host.
    typedef struct packed {
        logic [DataBits-1:0] data;
        logic                frameErr;  // stop bit was sampled low.
    } rxWord_t;

endpackage

// File: hdl/uartHostPkg.sv
package uartHostPkg;

    localparam int TxDepth = 4;  // bytes waiting for the transmitter.
    localparam int RxDepth = 4;  // received words waiting for the host.

    // Returned with every acknowledge. Only one flag can be set for a given operation.
    typedef struct packed {
        logic rejected;  // a write found the transmit FIFO full.
        logic empty;     // a read found nothing received.
        logic frameErr;  // the word read had a bad stop bit.
    } hostStatus_t;

endpackage

// File: hdl/uartFifo.sv
`timescale 1ns/1ps

module uartFifo #(
    parameter type payload_t = logic [7:0],
    parameter int  Depth     = 4
) (
    input  logic     i_Clk,
    input  logic     i_rstN,
    input  logic     i_Push,
    input  payload_t i_PushData,
    input  logic     i_Pop,
    output payload_t o_PopData,
    output logic     o_Empty,
    output logic     o_Full
);
    typedef logic [$clog2(Depth)-1:0]   ptr_t;
    typedef logic [$clog2(Depth+1)-1:0] count_t;

    payload_t r_Mem [Depth];
    ptr_t     r_WrPtr;
    ptr_t     r_RdPtr;
    count_t   r_Count;
    logic     w_Wr;
    logic     w_Rd;

    function automatic ptr_t nextPtr(ptr_t ptr);
        return (ptr == ptr_t'(Depth - 1)) ? '0 : ptr + 1'b1;  // wraps for any depth.
    endfunction

    assign w_Wr = i_Push && !o_Full;
    assign w_Rd = i_Pop && !o_Empty;
    assign o_Empty = (r_Count == '0);
    assign o_Full = (r_Count == count_t'(Depth));
    assign o_PopData = r_Mem[r_RdPtr];  // head is visible before the pop.

    always_ff @(posedge i_Clk) begin
        if (w_Wr) begin
            r_Mem[r_WrPtr] <= i_PushData;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            r_WrPtr <= '0;
            r_RdPtr <= '0;
            r_Count <= '0;
        end else begin
            if (w_Wr) begin
                r_WrPtr <= nextPtr(r_WrPtr);
            end
            if (w_Rd) begin
                r_RdPtr <= nextPtr(r_RdPtr);
            end
            r_Count <= r_Count + count_t'(w_Wr) - count_t'(w_Rd);
        end
    end

    a_NoPushFull: assert property (@(posedge i_Clk) disable iff (!i_rstN) i_Push |-> !o_Full)
        else $error("uartFifo: push while full");

    a_NoPopEmpty: assert property (@(posedge i_Clk) disable iff (!i_rstN) i_Pop |-> !o_Empty)
        else $error("uartFifo: pop while empty");

endmodule

// File: hdl/uartTx.sv
`timescale 1ns/1ps

module uartTx (
    input  logic                                     i_Clk,
    input  logic                                     i_rstN,
    input  logic [uartFramePkg::ClksPerBitWidth-1:0] i_ClksPerBit,
    input  logic                                     i_TxEn,
    input  logic [uartFramePkg::DataBits-1:0]        i_Data,
    output logic                                     o_TxDone,
    output logic                                     o_UART_TX
);
    import uartFramePkg::*;

    typedef enum logic [1:0] {
        TxWait,
        TxStart,
        TxData,
        TxStop
    } txState_t;

    typedef logic [$clog2(DataBits)-1:0] bitIdx_t;

    txState_t                   r_State;
    logic [ClksPerBitWidth-1:0] r_ClkCount;
    bitIdx_t                    r_BitIdx;
    logic [DataBits-1:0]        r_Data;
    logic                       w_BitEnd;

    assign w_BitEnd = (r_ClkCount == i_ClksPerBit - 1'b1);

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            r_State <= TxWait;
            r_ClkCount <= '0;
            r_BitIdx <= '0;
            o_TxDone <= 1'b1;
            o_UART_TX <= 1'b1;
        end else begin
            case (r_State)
                TxWait: begin
                    o_UART_TX <= 1'b1;
                    r_ClkCount <= '0;
                    r_BitIdx <= '0;
                    if (i_TxEn) begin
                        o_TxDone <= 1'b0;
                        r_State <= TxStart;
                    end else begin
                        o_TxDone <= 1'b1;
                    end
                end
                TxStart: begin
                    o_UART_TX <= 1'b0;
                    r_ClkCount <= w_BitEnd ? '0 : r_ClkCount + 1'b1;
                    if (w_BitEnd) begin
                        r_State <= TxData;
                    end
                end
                TxData: begin
                    o_UART_TX <= r_Data[r_BitIdx];  // LSB goes out first.
                    r_ClkCount <= w_BitEnd ? '0 : r_ClkCount + 1'b1;
                    if (w_BitEnd) begin
                        r_BitIdx <= r_BitIdx + 1'b1;
                        if (r_BitIdx == bitIdx_t'(DataBits - 1)) begin
                            r_State <= TxStop;
                        end
                    end
                end
                TxStop: begin
                    o_UART_TX <= 1'b1;
                    r_ClkCount <= w_BitEnd ? '0 : r_ClkCount + 1'b1;
                    if (w_BitEnd) begin
                        o_TxDone <= 1'b1;
                        r_State <= TxWait;
                    end
                end
                default: r_State <= TxWait;
            endcase
        end
    end

    // the byte is captured at acceptance so the FIFO head can move on during the frame.
    always_ff @(posedge i_Clk) begin
        if (r_State == TxWait && i_TxEn) begin
            r_Data <= i_Data;
        end
    end

    a_MinBitPeriod: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        i_TxEn |-> i_ClksPerBit >= ClksPerBitWidth'(MinClksPerBit))
        else $error("uartTx: bit period %0d below minimum", i_ClksPerBit);

endmodule

// File: hdl/uartRx.sv
`timescale 1ns/1ps

module uartRx (
    input  logic                                     i_Clk,
    input  logic                                     i_rstN,
    input  logic [uartFramePkg::ClksPerBitWidth-1:0] i_ClksPerBit,
    input  logic                                     i_UART_RX,
    output logic                                     o_RxValid,
    output uartFramePkg::rxWord_t                    o_RxWord
);
    import uartFramePkg::*;

    typedef enum logic [1:0] {
        RxIdle,
        RxStart,
        RxData,
        RxStop
    } rxState_t;

    typedef logic [$clog2(DataBits)-1:0] bitIdx_t;

    rxState_t                   r_State;
    logic [ClksPerBitWidth-1:0] r_ClkCount;
    bitIdx_t                    r_BitIdx;
    logic [DataBits-1:0]        r_Shift;
    logic                       r_RxMeta;
    logic                       r_RxSync;
    logic                       r_RxPrev;
    logic                       w_BitEnd;
    logic                       w_HalfBit;

    assign w_BitEnd = (r_ClkCount == i_ClksPerBit - 1'b1);
    assign w_HalfBit = (r_ClkCount == (i_ClksPerBit >> 1) - 1'b1);

    // the line idles high, so the synchronizer resets to one to avoid a false start edge.
    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            r_RxMeta <= 1'b1;
            r_RxSync <= 1'b1;
            r_RxPrev <= 1'b1;
        end else begin
            r_RxMeta <= i_UART_RX;
            r_RxSync <= r_RxMeta;
            r_RxPrev <= r_RxSync;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            r_State <= RxIdle;
            r_ClkCount <= '0;
            r_BitIdx <= '0;
            o_RxValid <= 1'b0;
        end else begin
            o_RxValid <= 1'b0;
            case (r_State)
                RxIdle: begin
                    r_ClkCount <= '0;
                    r_BitIdx <= '0;
                    if (r_RxPrev && !r_RxSync) begin
                        r_State <= RxStart;
                    end
                end
                RxStart: begin
                    r_ClkCount <= w_HalfBit ? '0 : r_ClkCount + 1'b1;
                    if (w_HalfBit) begin
                        r_State <= r_RxSync ? RxIdle : RxData;  // a short glitch is not a start bit.
                    end
                end
                RxData: begin
                    r_ClkCount <= w_BitEnd ? '0 : r_ClkCount + 1'b1;
                    if (w_BitEnd) begin
                        r_BitIdx <= r_BitIdx + 1'b1;
                        if (r_BitIdx == bitIdx_t'(DataBits - 1)) begin
                            r_State <= RxStop;
                        end
                    end
                end
                RxStop: begin
                    r_ClkCount <= w_BitEnd ? '0 : r_ClkCount + 1'b1;
                    if (w_BitEnd) begin
                        o_RxValid <= 1'b1;  // reported half a bit into the stop bit.
                        r_State <= RxIdle;
                    end
                end
                default: r_State <= RxIdle;
            endcase
        end
    end

    always_ff @(posedge i_Clk) begin
        if (w_BitEnd && r_State == RxData) begin
            r_Shift <= {r_RxSync, r_Shift[DataBits-1:1]};
        end
        if (w_BitEnd && r_State == RxStop) begin
            o_RxWord.data <= r_Shift;
            o_RxWord.frameErr <= !r_RxSync;
        end
    end

    a_ValidPulse: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        o_RxValid |=> !o_RxValid)
        else $error("uartRx: o_RxValid held longer than one cycle");

endmodule

// File: hdl/uartCtrl.sv
`timescale 1ns/1ps

module uartCtrl (
    input  logic                              i_Clk,
    input  logic                              i_rstN,
    input  logic                              i_Req,
    input  logic                              i_Write,
    input  logic [uartFramePkg::DataBits-1:0] i_WrData,
    output logic                              o_Ack,
    output logic [uartFramePkg::DataBits-1:0] o_RdData,
    output uartHostPkg::hostStatus_t          o_Status,
    output logic                              o_TxPush,
    output logic [uartFramePkg::DataBits-1:0] o_TxPushData,
    input  logic                              i_TxFull,
    input  logic                              i_TxEmpty,
    output logic                              o_TxPop,
    input  logic [uartFramePkg::DataBits-1:0] i_TxHead,
    output logic                              o_TxEn,
    input  logic                              i_TxDone,
    input  logic                              i_RxValid,
    input  uartFramePkg::rxWord_t             i_RxWord,
    output logic                              o_RxPush,
    output uartFramePkg::rxWord_t             o_RxPushData,
    input  logic                              i_RxFull,
    input  logic                              i_RxEmpty,
    output logic                              o_RxPop,
    input  uartFramePkg::rxWord_t             i_RxHead
);
    import uartFramePkg::*;
    import uartHostPkg::*;

    typedef enum logic [1:0] {
        HsIdle,
        HsOperate,
        HsAck,
        HsRelease
    } hsState_t;

    hsState_t            r_State;
    hostStatus_t         w_Status;
    logic [DataBits-1:0] w_RdData;
    logic                w_Operate;

    assign w_Operate = (r_State == HsOperate);
    assign o_TxPush = w_Operate && i_Write && !i_TxFull;
    assign o_TxPushData = i_WrData;
    assign o_RxPop = w_Operate && !i_Write && !i_RxEmpty;

    // a word arriving while the receive FIFO is full is lost.
    assign o_RxPush = i_RxValid && !i_RxFull;
    assign o_RxPushData = i_RxWord;

    always_comb begin
        w_Status = '0;
        w_RdData = '0;
        if (i_Write) begin
            w_Status.rejected = i_TxFull;
        end else if (i_RxEmpty) begin
            w_Status.empty = 1'b1;
        end else begin
            w_RdData = i_RxHead.data;
            w_Status.frameErr = i_RxHead.frameErr;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (w_Operate) begin
            o_RdData <= w_RdData;  // held until the next operation.
            o_Status <= w_Status;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            r_State <= HsIdle;
            o_Ack <= 1'b0;
        end else begin
            case (r_State)
                HsIdle: if (i_Req) r_State <= HsOperate;
                HsOperate: r_State <= HsAck;
                HsAck: begin
                    o_Ack <= 1'b1;
                    r_State <= HsRelease;
                end
                HsRelease: begin
                    if (!i_Req) begin
                        o_Ack <= 1'b0;
                        r_State <= HsIdle;
                    end
                end
                default: r_State <= HsIdle;
            endcase
        end
    end

    // One-cycle start pulse. The guard on o_TxEn covers the cycle before o_TxDone falls.
    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            o_TxEn <= 1'b0;
        end else begin
            o_TxEn <= i_TxDone && !i_TxEmpty && !o_TxEn;
        end
    end

    assign o_TxPop = o_TxEn;

    a_AckNeedsReq: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        $rose(o_Ack) |-> i_Req)
        else $error("uartCtrl: o_Ack rose without i_Req");

endmodule

// File: hdl/uartTop.sv
`timescale 1ns/1ps

module uartTop (
    input  logic                                     i_Clk,
    input  logic                                     i_rstN,
    input  logic [uartFramePkg::ClksPerBitWidth-1:0] i_ClksPerBit,
    input  logic                                     i_Req,
    input  logic                                     i_Write,
    input  logic [uartFramePkg::DataBits-1:0]        i_WrData,
    output logic                                     o_Ack,
    output logic [uartFramePkg::DataBits-1:0]        o_RdData,
    output uartHostPkg::hostStatus_t                 o_Status,
    output logic                                     o_UART_TX,
    input  logic                                     i_UART_RX
);
    import uartFramePkg::*;
    import uartHostPkg::*;

    logic                w_TxPush;
    logic [DataBits-1:0] w_TxPushData;
    logic                w_TxFull;
    logic                w_TxEmpty;
    logic                w_TxPop;
    logic [DataBits-1:0] w_TxHead;
    logic                w_TxEn;
    logic                w_TxDone;
    logic                w_RxValid;
    rxWord_t             w_RxWord;
    logic                w_RxPush;
    rxWord_t             w_RxPushData;
    logic                w_RxFull;
    logic                w_RxEmpty;
    logic                w_RxPop;
    rxWord_t             w_RxHead;

    uartCtrl u_ctrl (
        .i_Clk        (i_Clk),
        .i_rstN       (i_rstN),
        .i_Req        (i_Req),
        .i_Write      (i_Write),
        .i_WrData     (i_WrData),
        .o_Ack        (o_Ack),
        .o_RdData     (o_RdData),
        .o_Status     (o_Status),
        .o_TxPush     (w_TxPush),
        .o_TxPushData (w_TxPushData),
        .i_TxFull     (w_TxFull),
        .i_TxEmpty    (w_TxEmpty),
        .o_TxPop      (w_TxPop),
        .i_TxHead     (w_TxHead),
        .o_TxEn       (w_TxEn),
        .i_TxDone     (w_TxDone),
        .i_RxValid    (w_RxValid),
        .i_RxWord     (w_RxWord),
        .o_RxPush     (w_RxPush),
        .o_RxPushData (w_RxPushData),
        .i_RxFull     (w_RxFull),
        .i_RxEmpty    (w_RxEmpty),
        .o_RxPop      (w_RxPop),
        .i_RxHead     (w_RxHead)
    );

    uartFifo #(.payload_t(logic [DataBits-1:0]), .Depth(TxDepth)) u_txFifo (
        .i_Clk      (i_Clk),
        .i_rstN     (i_rstN),
        .i_Push     (w_TxPush),
        .i_PushData (w_TxPushData),
        .i_Pop      (w_TxPop),
        .o_PopData  (w_TxHead),
        .o_Empty    (w_TxEmpty),
        .o_Full     (w_TxFull)
    );

    uartFifo #(.payload_t(rxWord_t), .Depth(RxDepth)) u_rxFifo (
        .i_Clk      (i_Clk),
        .i_rstN     (i_rstN),
        .i_Push     (w_RxPush),
        .i_PushData (w_RxPushData),
        .i_Pop      (w_RxPop),
        .o_PopData  (w_RxHead),
        .o_Empty    (w_RxEmpty),
        .o_Full     (w_RxFull)
    );

    // the transmitter reads the FIFO head directly and latches it when it accepts.
    uartTx u_tx (
        .i_Clk        (i_Clk),
        .i_rstN       (i_rstN),
        .i_ClksPerBit (i_ClksPerBit),
        .i_TxEn       (w_TxEn),
        .i_Data       (w_TxHead),
        .o_TxDone     (w_TxDone),
        .o_UART_TX    (o_UART_TX)
    );

    uartRx u_rx (
        .i_Clk        (i_Clk),
        .i_rstN       (i_rstN),
        .i_ClksPerBit (i_ClksPerBit),
        .i_UART_RX    (i_UART_RX),
        .o_RxValid    (w_RxValid),
        .o_RxWord     (w_RxWord)
    );

endmodule

// File: tests/uartChecker.sv
`timescale 1ns/1ps

module uartChecker (
    input  logic                                     i_Clk,
    input  logic                                     i_rstN,
    input  logic [uartFramePkg::ClksPerBitWidth-1:0] i_ClksPerBit,
    input  logic                                     i_Line,
    input  logic                                     i_Ack,
    input  logic [uartFramePkg::DataBits-1:0]        i_RdData,
    input  uartHostPkg::hostStatus_t                 i_Status
);
    import uartFramePkg::*;
    import uartHostPkg::*;

    logic [9:0]  expFrames [$];  // bit 0 is the start bit.
    logic [11:0] expOps [$];     // {isRead, data, status}.
    string       testName;
    int          frameErrors;
    int          hostErrors;
    logic        prevLine;
    logic        prevAck;

    initial begin
        testName = "reset";
        frameErrors = 0;
        hostErrors = 0;
        prevLine = 1'b1;
        prevAck = 1'b0;
    end

    // the line is sampled on the falling clock edge, half a bit into each bit.
    always begin : decodeLine
        logic [9:0] frame;
        logic       haveExp;
        int         n;
        @(negedge i_Clk);
        if (i_rstN && prevLine && !i_Line) begin
            n = int'(i_ClksPerBit);
            haveExp = (expFrames.size() != 0);
            frame = '0;
            if (haveExp) begin
                frame = expFrames.pop_front();
            end else begin
                $display("%s: a frame started on the serial line with none expected", testName);
                frameErrors++;
            end
            repeat (n / 2) @(negedge i_Clk);
            for (int i = 0; i < 10; i++) begin
                if (i > 0) begin
                    repeat (n) @(negedge i_Clk);
                end
                if (haveExp && i_Line !== frame[i]) begin
                    $display("[FAIL] %s frame bit %0d: expected %b, actual %b",
                             testName, i, frame[i], i_Line);
                    frameErrors++;
                end
            end
            prevLine = 1'b1;
        end else begin
            prevLine = i_Line;
        end
    end

    always @(negedge i_Clk) begin : compareHost
        logic [11:0] exp;
        if (i_rstN && i_Ack && !prevAck) begin
            if (expOps.size() == 0) begin
                $display("%s: the DUT acknowledged with no operation pending", testName);
                hostErrors++;
            end else begin
                exp = expOps.pop_front();
                if (i_Status !== exp[2:0]) begin
                    $display("[FAIL] %s status: expected %b, actual %b",
                             testName, exp[2:0], i_Status);
                    hostErrors++;
                end
                if (exp[11] && i_RdData !== exp[10:3]) begin
                    $display("[FAIL] %s read data: expected %h, actual %h",
                             testName, exp[10:3], i_RdData);
                    hostErrors++;
                end
            end
        end
        prevAck = i_Ack;
    end

endmodule

// File: tests/uartTopTb.sv
`timescale 1ns/1ps

module uartTopTb;
    import uartFramePkg::*;
    import uartHostPkg::*;

    localparam int FastBits = 16;
    localparam int OddBits = 37;
    localparam int SlowBits = 200;
    localparam int BytesPerRate = 6;
    localparam int BurstWrites = TxDepth + 3;
    // frames at each bit period, plus the forced low line, plus slack for handshakes.
    localparam int CycleLimit = BytesPerRate * 10 * (FastBits + OddBits)
                              + (TxDepth + 1) * 10 * SlowBits + 20 * FastBits + 5000;

    logic                       clk;
    logic                       rstN;
    logic [ClksPerBitWidth-1:0] clksPerBit;
    logic                       req;
    logic                       write;
    logic [DataBits-1:0]        wrData;
    logic                       ack;
    logic [DataBits-1:0]        rdData;
    hostStatus_t                status;
    logic                       txLine;
    logic                       forceLow;
    logic                       rxLine;
    integer                     seed;
    int                         cycles;
    int                         tbErrors;
    int                         total;
    logic [DataBits-1:0]        b;
    logic [DataBits-1:0]        burst [BurstWrites];

    assign rxLine = forceLow ? 1'b0 : txLine;  // loopback with a stuck-low fault.

    uartTop u_dut (
        .i_Clk        (clk),
        .i_rstN       (rstN),
        .i_ClksPerBit (clksPerBit),
        .i_Req        (req),
        .i_Write      (write),
        .i_WrData     (wrData),
        .o_Ack        (ack),
        .o_RdData     (rdData),
        .o_Status     (status),
        .o_UART_TX    (txLine),
        .i_UART_RX    (rxLine)
    );

    uartChecker u_chk (
        .i_Clk        (clk),
        .i_rstN       (rstN),
        .i_ClksPerBit (clksPerBit),
        .i_Line       (txLine),
        .i_Ack        (ack),
        .i_RdData     (rdData),
        .i_Status     (status)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CycleLimit) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // start bit, data LSB first, stop bit.
    function automatic logic [9:0] buildFrame(input logic [DataBits-1:0] data);
        return {1'b1, data, 1'b0};
    endfunction

    task automatic hostOp(input logic wr, input logic [DataBits-1:0] data);
        @(posedge clk);
        req <= 1'b1;
        write <= wr;
        wrData <= data;
        do @(posedge clk); while (!ack);
        req <= 1'b0;
        do @(posedge clk); while (ack);
    endtask

    task automatic writeByte(input logic [DataBits-1:0] data, input logic rejected);
        u_chk.expOps.push_back({1'b0, 8'h00, rejected, 2'b00});
        if (!rejected) begin
            u_chk.expFrames.push_back(buildFrame(data));
        end
        hostOp(1'b1, data);
    endtask

    task automatic readByte(input logic [DataBits-1:0] data, input logic [2:0] st);
        u_chk.expOps.push_back({1'b1, data, st});
        hostOp(1'b0, 8'h00);
    endtask

    task automatic waitRx();
        while (u_dut.w_RxEmpty) @(posedge clk);
    endtask

    task automatic waitTxIdle();
        while (!(u_dut.w_TxDone && u_dut.w_TxEmpty)) @(posedge clk);
    endtask

    task automatic sendAndReadBack(input int bits);
        clksPerBit <= ClksPerBitWidth'(bits);
        for (int i = 0; i < BytesPerRate; i++) begin
            b = 8'($random(seed));
            writeByte(b, 1'b0);
            waitRx();
            readByte(b, 3'b000);
        end
        waitTxIdle();
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        clksPerBit = ClksPerBitWidth'(FastBits);
        req = 1'b0;
        write = 1'b0;
        wrData = '0;
        forceLow = 1'b0;
        seed = 32'h136b;
        cycles = 0;
        tbErrors = 0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        u_chk.testName = "idle after reset";
        repeat (50) begin
            @(posedge clk);
            if (ack !== 1'b0 || txLine !== 1'b1) begin
                $display("[FAIL] %s: expected ack 0 tx 1, actual ack %b tx %b",
                         u_chk.testName, ack, txLine);
                tbErrors++;
            end
        end

        u_chk.testName = "empty read";
        readByte(8'h00, 3'b010);

        u_chk.testName = "loopback fast";
        sendAndReadBack(FastBits);
        u_chk.testName = "loopback odd";
        sendAndReadBack(OddBits);

        u_chk.testName = "burst to full FIFO";
        clksPerBit <= ClksPerBitWidth'(SlowBits);
        for (int i = 0; i < BurstWrites; i++) begin
            burst[i] = 8'($random(seed));
            writeByte(burst[i], i > TxDepth);  // the first byte is already in the transmitter.
        end
        for (int i = 0; i <= TxDepth; i++) begin
            waitRx();
            readByte(burst[i], 3'b000);
        end
        waitTxIdle();

        u_chk.testName = "stuck low line";
        clksPerBit <= ClksPerBitWidth'(FastBits);
        @(posedge clk);
        forceLow <= 1'b1;
        repeat (12 * FastBits) @(posedge clk);
        forceLow <= 1'b0;
        waitRx();
        readByte(8'h00, 3'b001);
        repeat (4) @(posedge clk);

        if (u_chk.expFrames.size() != 0 || u_chk.expOps.size() != 0) begin
            $display("some expected frames or host operations never happened");
            tbErrors++;
        end
        total = tbErrors + u_chk.frameErrors + u_chk.hostErrors;
        $display("errors: testbench %0d, frame %0d, host %0d",
                 tbErrors, u_chk.frameErrors, u_chk.hostErrors);
        if (total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: uartTop.f
hdl/uartFramePkg.sv
hdl/uartHostPkg.sv
hdl/uartFifo.sv
hdl/uartTx.sv
hdl/uartRx.sv
hdl/uartCtrl.sv
hdl/uartTop.sv
tests/uartChecker.sv
tests/uartTopTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f uartTop.f --top-module uartTopTb -o VuartTopTb
	./obj_dir/VuartTopTb | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
